// File: verification/cache_tests.txt
// Columns in hex: byte address, expected rd_hit, expected rd_data (address with bit 0 cleared XOR A5C3).
// Blocks 0100, 0200 and 0300 share set 0; 1230 sits in set 3.
0107 0 A4C5
0100 1 A4C3
0102 1 A4C1
0104 1 A4C7
0106 1 A4C5
0108 1 A4CB
010A 1 A4C9
010C 1 A4CF
010E 1 A4CD
0208 0 A7CB
010A 1 A4C9
0202 1 A7C1
010C 1 A4CF
0304 0 A6C7
010E 1 A4CD
0206 0 A7C5
0100 1 A4C3
030E 0 A6CD
1234 0 B7F7
123A 1 B7F9
0109 1 A4CB

// File: build.f
design/cache_geom_pkg.sv
design/mem_bus_pkg.sv
design/way_if.sv
design/cache_way.sv
design/way_select.sv
design/cache_fill_ctrl.sv
design/cache_top.sv
verification/cache_sva.sv
verification/cache_tb.sv

// File: Makefile
# Verilator build and run of the two-way read cache testbench.
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       ?= cache_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Simulation FAILED" $(LOG) || \
	   ! grep -q "Simulation PASSED" $(LOG); then \
	  echo "test: failure found in $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: verification/cache_tb.sv
/*
 * Testbench for the read cache: clock, reset, memory model,
 * requests read from the tests file, and result checks.
 */
`timescale 1ns/1ps

module cache_tb;

  localparam logic [15:0] data_key        = 16'hA5C3; // Memory word is its address XOR this.
  localparam int          reset_cycles    = 16;       // Cycles spent in reset.
  localparam int          cycles_per_test = 60;       // Cycle budget for one request.

  logic        clk;               // Testbench clock.
  logic        rst_n;             // Synchronous reset, active low.
  logic        rd_req;            // Host read strobe.
  logic [15:0] rd_addr;           // Host byte address.
  logic        rd_valid;          // Result strobe from the DUT.
  logic [15:0] rd_data;           // Returned word.
  logic        rd_hit;            // Hit flag of the result.
  logic        busy;              // DUT stall.
  logic [15:0] memory_address;    // Word address from the DUT.
  logic [15:0] memory_data;       // Word from the memory model.
  logic        memory_data_valid; // Memory word strobe.

  logic [15:0] test_addr [$];     // Request addresses from the file.
  logic        test_hit  [$];     // Expected hit flags.
  logic [15:0] test_data [$];     // Expected words.
  logic [15:0] fill_base;         // Block base of the request in flight.
  integer      seed        = 88;  // Seed for the memory gaps.
  int          error_count = 0;
  int          cycle_limit = 0;
  int          cycle_count = 0;

  cache_top #(.num_ways(2)) dut0 (
    .clk               (clk),
    .rst_n             (rst_n),
    .rd_req            (rd_req),
    .rd_addr           (rd_addr),
    .rd_valid          (rd_valid),
    .rd_data           (rd_data),
    .rd_hit            (rd_hit),
    .busy              (busy),
    .memory_address    (memory_address),
    .memory_data       (memory_data),
    .memory_data_valid (memory_data_valid)
  );

  ////////////////////////////////////////////////////////////
  // Failure reporting and file input
  ////////////////////////////////////////////////////////////
  task automatic abort_run(input string why);
    error_count++;
    $display("%s", why);              // Cause first, then the verdict.
    $display("Simulation FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic report_mismatch(input string name, input logic [15:0] expected,
                                 input logic [15:0] actual);
    abort_run($sformatf("[FAIL] %s expected 0x%04h got 0x%04h", name, expected, actual));
  endtask

  // Each data line holds address, hit flag and word, all hex. Comment lines do not parse.
  task automatic read_tests();
    int          fd;
    string       line;
    logic [15:0] addr;
    logic [15:0] hit;
    logic [15:0] data;
    fd = $fopen("verification/cache_tests.txt", "r");
    if (fd == 0) begin
      abort_run("Could not open the tests file verification/cache_tests.txt.");
    end else begin
      while ($fgets(line, fd) > 0) begin
        if ($sscanf(line, "%h %h %h", addr, hit, data) == 3) begin
          test_addr.push_back(addr);
          test_hit.push_back(hit[0]);
          test_data.push_back(data);
        end
      end
      $fclose(fd);
      if (test_addr.size() == 0) abort_run("The tests file holds no requests.");
    end
  endtask

  ////////////////////////////////////////////////////////////
  // One request: wait for idle, strobe, wait for the result
  ////////////////////////////////////////////////////////////
  task automatic issue_request(input logic [15:0] addr, input logic exp_hit,
                               input logic [15:0] exp_data);
    int   latency;
    logic saw_busy;
    latency  = 0;
    saw_busy = 1'b0;
    while (busy) begin
      @(posedge clk);
      #2;
    end
    fill_base = {addr[15:4], 4'h0};   // The memory model checks fills against this.
    rd_addr   = addr;
    rd_req    = 1'b1;                 // Single-cycle strobe.
    @(posedge clk);
    #2;
    rd_req = 1'b0;
    while (!rd_valid) begin
      @(posedge clk);
      #2;
      latency++;                      // Edges since the request was sampled.
      if (busy) saw_busy = 1'b1;      // A miss must stall the host.
    end
    assert (rd_hit == exp_hit) else report_mismatch("rd_hit", 16'(exp_hit), 16'(rd_hit));
    assert (rd_data == exp_data) else report_mismatch("rd_data", exp_data, rd_data);
    assert (busy == 1'b0) else report_mismatch("busy", 16'h0000, 16'(busy));
    if (exp_hit) begin
      assert (latency == 1)
        else abort_run($sformatf("A hit at 0x%04h took %0d cycles instead of one.", addr, latency));
    end else begin
      assert (saw_busy)
        else abort_run($sformatf("The miss at 0x%04h never raised busy.", addr));
    end
  endtask

  initial begin : clock_gen
    clk = 1'b0;
    forever #20 clk = ~clk;           // 40 ns period.
  end

  ////////////////////////////////////////////////////////////
  // Memory model with random gaps between words
  ////////////////////////////////////////////////////////////
  initial begin : memory_model
    int          sent;
    int          gap;
    logic [15:0] expected_addr;
    sent              = 0;
    gap               = 0;
    memory_data       = '0;
    memory_data_valid = 1'b0;
    forever begin
      @(posedge clk);
      #2;
      memory_data_valid = 1'b0;       // Strobes last one cycle.
      if (busy !== 1'b1) begin
        sent = 0;                     // Ready for the next fill.
      end else if (sent < 8) begin
        if (gap > 0) begin
          gap--;
        end else begin
          expected_addr = fill_base + 16'(2 * sent);
          assert (memory_address == expected_addr)
            else report_mismatch("memory_address", expected_addr, memory_address);
          memory_data       = memory_address ^ data_key;
          memory_data_valid = 1'b1;
          sent++;
          gap = $random(seed) & 3;    // Zero to three idle cycles.
        end
      end
    end
  end

  initial begin : watchdog
    wait (rst_n === 1'b1);
    while (cycle_count < cycle_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    abort_run($sformatf("Timeout: the requests did not finish in %0d cycles.", cycle_limit));
  end

  initial begin : stimulus
    rst_n     = 1'b0;
    rd_req    = 1'b0;
    rd_addr   = '0;
    fill_base = '0;
    read_tests();
    cycle_limit = test_addr.size() * cycles_per_test;
    repeat (reset_cycles) @(posedge clk);
    #2;
    rst_n = 1'b1;
    for (int i = 0; i < test_addr.size(); i++) begin
      issue_request(test_addr[i], test_hit[i], test_data[i]);
    end
    if (error_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// File: verification/cache_sva.sv
/*
 * Protocol assertions of the read cache, bound into cache_top.
 */
`timescale 1ns/1ps

module cache_sva (
  input logic clk,      // System clock.
  input logic rst_n,    // Synchronous reset, active low.
  input logic rd_req,   // Host read strobe.
  input logic busy,     // Cache stall.
  input logic rd_valid, // Result strobe.
  input logic data_wr,  // A fill word is written to the victim.
  input logic tag_wr    // The victim tag is written.
);

  logic [3:0] data_writes; // Fill words since the last tag write.

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      data_writes <= '0;
    end else if (tag_wr) begin
      data_writes <= '0;                  // Next fill counts from zero.
    end else if (data_wr) begin
      data_writes <= data_writes + 4'd1;
    end
  end

  no_req_while_busy: assert property (@(posedge clk) disable iff (!rst_n) busy |-> !rd_req)
    else $error("rd_req was strobed while busy was high.");

  tag_after_eight: assert property (@(posedge clk) disable iff (!rst_n)
                                    tag_wr |-> (data_writes == 4'd8))
    else $error("The tag was written before eight data words.");

  // The result strobe is a single-cycle pulse.
  valid_one_cycle: assert property (@(posedge clk) disable iff (!rst_n) rd_valid |=> !rd_valid)
    else $error("rd_valid stayed high for more than one cycle.");

endmodule

bind cache_top cache_sva sva0 (
  .clk      (clk),
  .rst_n    (rst_n),
  .rd_req   (rd_req),
  .busy     (busy),
  .rd_valid (rd_valid),
  .data_wr  (u_ctrl.incr_cnt),
  .tag_wr   (u_ctrl.tag_wr)
);

// File: design/cache_top.sv
/*
 * Top level of the read cache: fill controller, ways and way selector.
 */
`timescale 1ns/1ps

module cache_top #(
  parameter int num_ways = 2                                // Number of ways, power of two.
) (
  input  logic                              clk,               // System clock.
  input  logic                              rst_n,             // Synchronous reset, active low.
  input  logic                              rd_req,            // Read strobe from the host.
  input  logic [cache_geom_pkg::addr_w-1:0] rd_addr,           // Byte address of the read.
  output logic                              rd_valid,          // Result strobe.
  output logic [mem_bus_pkg::data_w-1:0]    rd_data,           // Returned word.
  output logic                              rd_hit,            // The read hit without a fill.
  output logic                              busy,              // Host must not strobe now.
  output logic [cache_geom_pkg::addr_w-1:0] memory_address,    // Word address to memory.
  input  logic [mem_bus_pkg::data_w-1:0]    memory_data,       // Word from memory.
  input  logic                              memory_data_valid  // Memory word strobe.
);

  way_if way_bus [num_ways] ();                         // One bus per way.

  logic                           lookup_hit;           // Hit reduced over the ways.
  logic [mem_bus_pkg::data_w-1:0] lookup_word;          // Word of the hitting way.
  logic [$clog2(num_ways)-1:0]    victim;               // Way to refill.

  cache_fill_ctrl #(.num_ways(num_ways)) u_ctrl (
    .clk               (clk),
    .rst_n             (rst_n),
    .rd_req            (rd_req),
    .rd_addr           (rd_addr),
    .memory_data       (memory_data),
    .memory_data_valid (memory_data_valid),
    .ways              (way_bus),
    .lookup_hit        (lookup_hit),
    .lookup_word       (lookup_word),
    .victim            (victim),
    .rd_valid          (rd_valid),
    .rd_data           (rd_data),
    .rd_hit            (rd_hit),
    .busy              (busy),
    .memory_address    (memory_address)
  );

  for (genvar g = 0; g < num_ways; g++) begin : g_way
    cache_way u_way (
      .clk   (clk),
      .rst_n (rst_n),
      .bus   (way_bus[g])
    );
  end

  // All ways see the same index, way 0 carries it to the selector.
  cache_way_select #(.num_ways(num_ways)) u_sel (
    .clk         (clk),
    .rst_n       (rst_n),
    .ways        (way_bus),
    .index       (way_bus[0].index),
    .rd_valid    (rd_valid),
    .lookup_hit  (lookup_hit),
    .lookup_word (lookup_word),
    .victim      (victim)
  );

endmodule

// File: design/cache_fill_ctrl.sv
/*
 * Cache controller: request register, lookup handling and the block fill FSM.
 */
`timescale 1ns/1ps

module cache_fill_ctrl #(
  parameter int num_ways = 2                                // Number of cache ways.
) (
  input  logic                              clk,               // System clock.
  input  logic                              rst_n,             // Synchronous reset, active low.
  input  logic                              rd_req,            // Single-cycle read strobe.
  input  logic [cache_geom_pkg::addr_w-1:0] rd_addr,           // Byte address of the read.
  input  logic [mem_bus_pkg::data_w-1:0]    memory_data,       // Word returned by memory.
  input  logic                              memory_data_valid, // Strobe, one word per pulse.
  way_if.ctrl                               ways [num_ways],   // Addressing and fill writes.
  input  logic                              lookup_hit,        // Some way holds the block.
  input  logic [mem_bus_pkg::data_w-1:0]    lookup_word,       // Word from the hitting way.
  input  logic [$clog2(num_ways)-1:0]       victim,            // Way chosen for refill.
  output logic                              rd_valid,          // Result strobe to the host.
  output logic [mem_bus_pkg::data_w-1:0]    rd_data,           // Returned word.
  output logic                              rd_hit,            // First lookup was a hit.
  output logic                              busy,              // Stall while a miss is served.
  output logic [cache_geom_pkg::addr_w-1:0] memory_address     // Word address to memory.
);

  localparam int way_bits = $clog2(num_ways);
  localparam int cnt_w    = cache_geom_pkg::cnt_w;

  typedef enum logic [1:0] {IDLE, LOOKUP, FILL} state_t;

  state_t                               state;       // Current FSM state.
  state_t                               nxt_state;   // Next FSM state.
  logic [cache_geom_pkg::addr_w-1:0]    req_addr;    // Registered request address.
  logic [cnt_w-1:0]                     word_count;  // Words written in this fill.
  logic [cache_geom_pkg::word_bits-1:0] word_sel;    // Word slot driven to the ways.
  logic                                 miss_seen;   // This request needed a fill.
  logic                                 start_fill;  // Lookup missed, begin a fill.
  logic                                 incr_cnt;    // A memory word is written.
  logic                                 tag_wr;      // All words are in, write the tag.
  logic                                 respond;     // Return the result this cycle.
  logic                                 block_full;  // Eight words have arrived.

  ////////////////////////////////////////////////////////////
  // Drive every way
  ////////////////////////////////////////////////////////////
  // During a fill the slot follows the counter, otherwise the request.
  assign word_sel = (state == FILL) ? word_count[cache_geom_pkg::word_bits-1:0]
                                    : req_addr[cache_geom_pkg::offset_bits-1:1];

  for (genvar g = 0; g < num_ways; g++) begin : g_drive
    assign ways[g].index     = req_addr[cache_geom_pkg::tag_lsb-1:cache_geom_pkg::index_lsb];
    assign ways[g].tag       = req_addr[cache_geom_pkg::addr_w-1:cache_geom_pkg::tag_lsb];
    assign ways[g].word_sel  = word_sel;
    assign ways[g].fill_data = memory_data;                          // Memory word goes straight in.
    assign ways[g].wr_data   = incr_cnt && (victim == way_bits'(g)); // Only the victim fills.
    assign ways[g].wr_tag    = tag_wr && (victim == way_bits'(g));
  end

  ////////////////////////////////////////////////////////////
  // State machine
  ////////////////////////////////////////////////////////////
  assign block_full = (word_count == cnt_w'(cache_geom_pkg::words_per_block));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= IDLE;      // Wait for the first request.
    end else begin
      state <= nxt_state;
    end
  end

  always_comb begin
    nxt_state  = state;
    start_fill = 1'b0;
    incr_cnt   = 1'b0;
    tag_wr     = 1'b0;
    respond    = 1'b0;
    case (state)
      IDLE: begin
        if (rd_req) nxt_state = LOOKUP;   // Address is registered on this edge.
      end
      LOOKUP: begin
        if (lookup_hit) begin
          respond   = 1'b1;               // Data is ready, hand it back.
          nxt_state = IDLE;
        end else begin
          start_fill = 1'b1;              // Fetch the whole block.
          nxt_state  = FILL;
        end
      end
      FILL: begin
        if (block_full) begin
          tag_wr    = 1'b1;               // Tag goes in one cycle after the last word.
          nxt_state = LOOKUP;             // Lookup again, it must hit now.
        end else if (memory_data_valid) begin
          incr_cnt = 1'b1;
        end
      end
      default: nxt_state = IDLE;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Request and fill registers
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if ((state == IDLE) && rd_req) begin
      req_addr <= rd_addr;                // Hold the address for the whole request.
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      word_count     <= '0;
      memory_address <= '0;
    end else if (start_fill) begin
      word_count     <= '0;               // New fill starts at word zero.
      memory_address <= {req_addr[cache_geom_pkg::addr_w-1:cache_geom_pkg::offset_bits],
                         cache_geom_pkg::offset_bits'(0)}; // Block base address.
    end else if (incr_cnt) begin
      word_count     <= word_count + 1'b1;
      memory_address <= memory_address + cache_geom_pkg::addr_w'(mem_bus_pkg::word_step);
    end
  end

  // Busy covers the fill, the tag write and the final lookup.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy      <= 1'b0;
      miss_seen <= 1'b0;
    end else begin
      if (start_fill) busy <= 1'b1;
      else if (respond) busy <= 1'b0;     // Falls together with rd_valid.
      if ((state == IDLE) && rd_req) miss_seen <= 1'b0;
      else if (start_fill) miss_seen <= 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Result to the host
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_valid <= 1'b0;
      rd_hit   <= 1'b0;
    end else begin
      rd_valid <= respond;                // One-cycle strobe.
      rd_hit   <= respond && !miss_seen;  // Hit only if no fill was needed.
    end
  end

  always_ff @(posedge clk) begin
    if (respond) begin
      rd_data <= lookup_word;             // Word from the hitting way.
    end
  end

endmodule

// File: design/way_select.sv
/*
 * Way selector: hit reduction, word mux, and tree LRU bits that name the victim.
 */
`timescale 1ns/1ps

module cache_way_select #(
  parameter int num_ways = 2                                   // Power of two, 2 or 4.
) (
  input  logic                                  clk,         // System clock.
  input  logic                                  rst_n,       // Synchronous reset, active low.
  way_if.sel                                    ways [num_ways], // Answers of every way.
  input  logic [cache_geom_pkg::index_bits-1:0] index,       // Registered set index.
  input  logic                                  rd_valid,    // A result is being returned.
  output logic                                  lookup_hit,  // Some way holds the block.
  output logic [mem_bus_pkg::data_w-1:0]        lookup_word, // Word from the hitting way.
  output logic [$clog2(num_ways)-1:0]           victim       // Way to refill on a miss.
);

  localparam int way_bits = $clog2(num_ways);

  logic [num_ways-1:0]            hits;                            // Hit flags of all ways.
  logic [mem_bus_pkg::data_w-1:0] words [num_ways];                // Words of all ways.
  logic [way_bits-1:0]            hit_way;                         // Number of the hitting way.
  logic [num_ways-2:0]            lru [cache_geom_pkg::num_sets];  // Tree bits per set.

  for (genvar g = 0; g < num_ways; g++) begin : g_tap
    assign hits[g]  = ways[g].hit;     // Gather the way answers into plain arrays.
    assign words[g] = ways[g].rd_word;
  end

  // At most one way can hit, so the last match wins without conflict.
  always_comb begin
    hit_way     = '0;
    lookup_hit  = 1'b0;
    lookup_word = '0;
    for (int i = 0; i < num_ways; i++) begin
      if (hits[i]) begin
        hit_way     = way_bits'(i); // Remember which way answered.
        lookup_hit  = 1'b1;         // OR of all hits.
        lookup_word = words[i];     // Mux the hitting word.
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Tree LRU: a set bit means the right subtree is older.
  ////////////////////////////////////////////////////////////
  always_comb begin : victim_walk
    int unsigned node;
    node   = 0;
    victim = '0;
    for (int lvl = 0; lvl < way_bits; lvl++) begin
      victim[way_bits-1-lvl] = lru[index][node];      // Follow the older side.
      node = 2 * node + 1 + lru[index][node];         // Heap order child.
    end
  end

  always_ff @(posedge clk) begin : lru_update
    int unsigned node;
    if (!rst_n) begin
      for (int s = 0; s < cache_geom_pkg::num_sets; s++) begin
        lru[s] <= '0;                                 // Way 0 is the first victim.
      end
    end else if (rd_valid) begin
      node = 0;
      for (int lvl = 0; lvl < way_bits; lvl++) begin
        lru[index][node] <= ~hit_way[way_bits-1-lvl]; // Point away from the used way.
        node = 2 * node + 1 + hit_way[way_bits-1-lvl];
      end
    end
  end

endmodule

// File: design/cache_way.sv
/*
 * One cache way: valid bits, tag array, data array and the tag compare.
 */
`timescale 1ns/1ps

module cache_way (
  input  logic clk,   // System clock.
  input  logic rst_n, // Synchronous reset, active low.
  way_if.way   bus    // Lookup and fill port from the controller.
);

  localparam int depth = cache_geom_pkg::num_sets * cache_geom_pkg::words_per_block;
  localparam int addr_bits = cache_geom_pkg::index_bits + cache_geom_pkg::word_bits;

  ////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////
  logic [cache_geom_pkg::num_sets-1:0] valid;                          // One valid bit per set.
  logic [cache_geom_pkg::tag_bits-1:0] tags [cache_geom_pkg::num_sets]; // One tag per set.
  logic [mem_bus_pkg::data_w-1:0]      data [depth];                   // Eight words per set.
  logic [addr_bits-1:0]                word_addr;                      // Flat data array index.

  assign word_addr = {bus.index, bus.word_sel}; // Set selects the row, word the column.

  ////////////////////////////////////////////////////////////
  // Valid bits
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid <= '0;                 // Every set starts empty.
    end else if (bus.wr_tag) begin
      valid[bus.index] <= 1'b1;    // The tag write closes a complete fill.
    end
  end

  // Tag array, written once the block data is complete.
  always_ff @(posedge clk) begin
    if (bus.wr_tag) begin
      tags[bus.index] <= bus.tag;  // Store the tag of the new block.
    end
  end

  // Data array, one word per memory strobe.
  always_ff @(posedge clk) begin
    if (bus.wr_data) begin
      data[word_addr] <= bus.fill_data; // Place the returned word in its slot.
    end
  end

  ////////////////////////////////////////////////////////////
  // Lookup
  ////////////////////////////////////////////////////////////
  assign bus.hit     = valid[bus.index] && (tags[bus.index] == bus.tag); // Valid and same tag.
  assign bus.rd_word = data[word_addr];                                  // Addressed word.

endmodule

// File: design/way_if.sv
/*
 * Per-way bus between the fill controller, one cache way and the way selector.
 */
`timescale 1ns/1ps

interface way_if;

  logic [cache_geom_pkg::index_bits-1:0] index;     // Set index of the current request.
  logic [cache_geom_pkg::tag_bits-1:0]   tag;       // Tag to compare or to write.
  logic [cache_geom_pkg::word_bits-1:0]  word_sel;  // Word within the block.
  logic [mem_bus_pkg::data_w-1:0]        fill_data; // Word arriving from memory.
  logic                                  wr_data;   // Data array write enable.
  logic                                  wr_tag;    // Tag write, which also sets valid.
  logic                                  hit;       // Valid entry with matching tag.
  logic [mem_bus_pkg::data_w-1:0]        rd_word;   // Addressed word of this way.

  // The controller owns addressing and write strobes.
  modport ctrl (output index, tag, word_sel, fill_data, wr_data, wr_tag);

  modport way (input index, tag, word_sel, fill_data, wr_data, wr_tag,
               output hit, rd_word);

  // The selector only drains the lookup answer.
  modport sel (input hit, rd_word);

endinterface

// File: design/mem_bus_pkg.sv
/*
 * Widths of the memory bus and the address step between fill words.
 */
package mem_bus_pkg;

  ////////////////////////////////////////////////////////////
  // Memory word
  ////////////////////////////////////////////////////////////
  localparam int data_w    = 16;  // Width of one word on the memory bus.
  localparam int word_step = 2;   // Byte increment from one fill word to the next.

endpackage

// File: design/cache_geom_pkg.sv
/*
 * Geometry constants of the two-way read cache and the widths of the
 * tag, index and word fields of a byte address.
 */
package cache_geom_pkg;

  ////////////////////////////////////////////////////////////
  // Address and block shape
  ////////////////////////////////////////////////////////////
  localparam int addr_w          = 16;                // Byte address width.
  localparam int words_per_block = 8;                 // Words held by one block.
  localparam int offset_bits     = 4;                 // Byte offset bits within a block.
  localparam int index_bits      = 3;                 // Set index bits, address bits 6 to 4.
  localparam int tag_bits        = 9;                 // Tag bits, address bits 15 to 7.

  ////////////////////////////////////////////////////////////
  // Derived field positions
  ////////////////////////////////////////////////////////////
  localparam int word_bits = offset_bits - 1;         // Word select, address bits 3 to 1.
  localparam int num_sets  = 1 << index_bits;         // Eight sets per way.
  localparam int index_lsb = offset_bits;             // Lowest index bit of the address.
  localparam int tag_lsb   = offset_bits + index_bits; // Lowest tag bit of the address.
  localparam int cnt_w     = word_bits + 1;           // Fill counter must reach eight.

endpackage
